// File: verilog/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    // base opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASSB
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_JAL, BR_JALR
    } br_op_e;

    typedef enum logic [1:0] {OP1_RS1, OP1_PC, OP1_ZERO} op1_sel_e;
    typedef enum logic [1:0] {OP2_RS2, OP2_IMM} op2_sel_e;
    typedef enum logic {WB_ALU, WB_LINK} wb_sel_e;

    ////////////////////
    // instruction word views

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [19:0] upper;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } inst_uj_t;

    typedef union packed {
        inst_r_t  r;
        inst_uj_t uj;
    } inst_word_u;

    ////////////////////
    // control and stage records

    typedef struct packed {
        alu_op_e  alu_op;
        br_op_e   br_op;
        op1_sel_e op1_sel;
        op2_sel_e op2_sel;
        wb_sel_e  wb_sel;
        logic     rf_wen;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
    } ctrl_t;

    typedef struct packed {
        logic       valid;
        word_t      pc;
        inst_word_u inst;
    } fetch_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        ctrl_t ctrl;
        word_t op1;
        word_t op2;
        word_t rs2_val;
        word_t imm;
    } exe_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        logic     rf_wen;
        reg_idx_t rd;
        word_t    wdata;
    } retire_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
    } redirect_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } fwd_t;

endpackage

`default_nettype wire

// File: verilog/inst_decode.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
    input  core_pkg::inst_word_u inst_i,
    output core_pkg::ctrl_t      ctrl_o,
    output core_pkg::word_t      imm_o
);
    import core_pkg::*;

    word_t   imm_i_type;
    word_t   imm_b_type;
    word_t   imm_u_type;
    word_t   imm_j_type;
    alu_op_e alu_dec;

    assign imm_i_type = {{20{inst_i.r.funct7[6]}}, inst_i.r.funct7, inst_i.r.rs2};
    assign imm_b_type = {{19{inst_i.r.funct7[6]}}, inst_i.r.funct7[6], inst_i.r.rd[0],
                         inst_i.r.funct7[5:0], inst_i.r.rd[4:1], 1'b0};
    assign imm_u_type = {inst_i.uj.upper, 12'h000};
    // J format scatters imm[20|10:1|11|19:12] over the upper field
    assign imm_j_type = {{11{inst_i.uj.upper[19]}}, inst_i.uj.upper[19],
                         inst_i.uj.upper[7:0], inst_i.uj.upper[8],
                         inst_i.uj.upper[18:9], 1'b0};

    // funct3 map shared by OP and OP-IMM
    always_comb begin
        case (inst_i.r.funct3)
            3'b000:  alu_dec = ALU_ADD;
            3'b001:  alu_dec = ALU_SLL;
            3'b010:  alu_dec = ALU_SLT;
            3'b011:  alu_dec = ALU_SLTU;
            3'b100:  alu_dec = ALU_XOR;
            3'b101:  alu_dec = inst_i.r.funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  alu_dec = ALU_OR;
            default: alu_dec = ALU_AND;
        endcase
    end

    always_comb begin
        ctrl_o.alu_op  = ALU_ADD;
        ctrl_o.br_op   = BR_NONE;
        ctrl_o.op1_sel = OP1_RS1;
        ctrl_o.op2_sel = OP2_RS2;
        ctrl_o.wb_sel  = WB_ALU;
        ctrl_o.rf_wen  = 1'b0;
        ctrl_o.rd      = inst_i.r.rd;
        ctrl_o.rs1     = inst_i.r.rs1;
        ctrl_o.rs2     = inst_i.r.rs2;
        imm_o          = '0;

        case (inst_i.r.opcode)
            OPC_OP: begin
                ctrl_o.rf_wen = 1'b1;
                ctrl_o.alu_op = (inst_i.r.funct3 == 3'b000 && inst_i.r.funct7[5]) ?
                                ALU_SUB : alu_dec;
            end
            OPC_OPIMM: begin
                ctrl_o.rf_wen  = 1'b1;
                ctrl_o.alu_op  = alu_dec;
                ctrl_o.op2_sel = OP2_IMM;
                ctrl_o.rs2     = '0;
                imm_o          = imm_i_type;
            end
            OPC_LUI, OPC_AUIPC: begin
                ctrl_o.rf_wen  = 1'b1;
                ctrl_o.alu_op  = (inst_i.uj.opcode == OPC_LUI) ? ALU_PASSB : ALU_ADD;
                ctrl_o.op1_sel = OP1_PC;
                ctrl_o.op2_sel = OP2_IMM;
                ctrl_o.rd      = inst_i.uj.rd;
                ctrl_o.rs1     = '0;
                ctrl_o.rs2     = '0;
                imm_o          = imm_u_type;
            end
            OPC_JAL: begin
                ctrl_o.rf_wen  = 1'b1;
                ctrl_o.br_op   = BR_JAL;
                ctrl_o.wb_sel  = WB_LINK;
                ctrl_o.op1_sel = OP1_ZERO;
                ctrl_o.rd      = inst_i.uj.rd;
                ctrl_o.rs1     = '0;
                ctrl_o.rs2     = '0;
                imm_o          = imm_j_type;
            end
            OPC_JALR: begin
                ctrl_o.rf_wen = 1'b1;
                ctrl_o.br_op  = BR_JALR;
                ctrl_o.wb_sel = WB_LINK;
                ctrl_o.rs2    = '0;
                imm_o         = imm_i_type;
            end
            OPC_BRANCH: begin
                case (inst_i.r.funct3)
                    3'b000:  ctrl_o.br_op = BR_BEQ;
                    3'b001:  ctrl_o.br_op = BR_BNE;
                    3'b100:  ctrl_o.br_op = BR_BLT;
                    3'b101:  ctrl_o.br_op = BR_BGE;
                    3'b110:  ctrl_o.br_op = BR_BLTU;
                    3'b111:  ctrl_o.br_op = BR_BGEU;
                    default: ctrl_o.br_op = BR_NONE;
                endcase
                imm_o = imm_b_type;
            end
            // anything else retires as a no-op
            default: begin
                ctrl_o.rs1 = '0;
                ctrl_o.rs2 = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/int_alu.sv
`timescale 1ns/1ps
`default_nettype none

module int_alu (
    input  core_pkg::alu_op_e op_i,
    input  core_pkg::word_t   a_i,
    input  core_pkg::word_t   b_i,
    output core_pkg::word_t   result_o
);
    import core_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b_i[4:0];
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (op_i)
            ALU_ADD:  result_o = a_i + b_i;
            ALU_SUB:  result_o = a_i - b_i;
            ALU_AND:  result_o = a_i & b_i;
            ALU_OR:   result_o = a_i | b_i;
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_SLL:  result_o = a_i << shamt;
            ALU_SRL:  result_o = a_i >> shamt;
            ALU_SRA:  result_o = word_t'($signed(a_i) >>> shamt);
            // pass-b, LUI
            default:  result_o = b_i;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  core_pkg::br_op_e br_i,
    input  core_pkg::word_t  pc_i,
    input  core_pkg::word_t  rs1_i,
    input  core_pkg::word_t  rs2_i,
    input  core_pkg::word_t  imm_i,
    output logic             taken_o,
    output core_pkg::word_t  target_o,
    output core_pkg::word_t  link_o
);
    import core_pkg::*;

    logic  eq;
    logic  lt;
    logic  ltu;
    word_t jalr_sum;

    assign eq  = rs1_i == rs2_i;
    assign lt  = $signed(rs1_i) < $signed(rs2_i);
    assign ltu = rs1_i < rs2_i;

    always_comb begin
        case (br_i)
            BR_BEQ:          taken_o = eq;
            BR_BNE:          taken_o = ~eq;
            BR_BLT:          taken_o = lt;
            BR_BGE:          taken_o = ~lt;
            BR_BLTU:         taken_o = ltu;
            BR_BGEU:         taken_o = ~ltu;
            BR_JAL, BR_JALR: taken_o = 1'b1;
            default:         taken_o = 1'b0;
        endcase
    end

    // jalr drops bit 0 of the sum
    assign jalr_sum = rs1_i + imm_i;
    assign target_o = (br_i == BR_JALR) ? {jalr_sum[XLEN-1:1], 1'b0} : pc_i + imm_i;
    assign link_o   = pc_i + 32'd4;

endmodule

`default_nettype wire

// File: verilog/reg_file_wb.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file_wb #(
    parameter int NUM_REGS = 32
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              dec_valid_i,
    input  core_pkg::ctrl_t   ctrl_i,
    input  core_pkg::word_t   pc_i,
    input  core_pkg::word_t   imm_i,
    input  core_pkg::fwd_t    exe_fwd_i,
    input  core_pkg::exe_t    exe_i,
    input  core_pkg::word_t   alu_result_i,
    input  core_pkg::word_t   link_i,
    input  logic              flush_i,
    output core_pkg::word_t   op1_o,
    output core_pkg::word_t   op2_o,
    output core_pkg::word_t   rs2_val_o,
    output core_pkg::retire_t retire_o
);
    import core_pkg::*;

    localparam int IDX_W = $clog2(NUM_REGS);

    word_t    regs [NUM_REGS];
    retire_t  wb_q;
    logic     rd_en;
    reg_idx_t src_idx [2];
    word_t    src_val [2];

    ////////////////////
    // operand read

    // no read for a squashed or empty decode slot
    assign rd_en      = dec_valid_i & ~flush_i;
    assign src_idx[0] = ctrl_i.rs1;
    assign src_idx[1] = ctrl_i.rs2;

    // newest producer wins, x0 and unmapped indices read zero
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            src_val[s] = '0;
            if (rd_en && src_idx[s] != '0 && int'(src_idx[s]) < NUM_REGS) begin
                if (exe_fwd_i.valid && exe_fwd_i.rd == src_idx[s]) begin
                    src_val[s] = exe_fwd_i.data;
                end else if (wb_q.valid && wb_q.rf_wen && wb_q.rd == src_idx[s]) begin
                    src_val[s] = wb_q.wdata;
                end else begin
                    src_val[s] = regs[src_idx[s][IDX_W-1:0]];
                end
            end
        end
    end

    always_comb begin
        case (ctrl_i.op1_sel)
            OP1_RS1: op1_o = src_val[0];
            OP1_PC:  op1_o = pc_i;
            default: op1_o = '0;
        endcase
        op2_o     = (ctrl_i.op2_sel == OP2_IMM) ? imm_i : src_val[1];
        rs2_val_o = src_val[1];
    end

    ////////////////////
    // writeback

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_q.valid <= 1'b0;
        end else begin
            wb_q.valid  <= exe_i.valid;
            wb_q.pc     <= exe_i.pc;
            wb_q.rf_wen <= exe_i.ctrl.rf_wen;
            wb_q.rd     <= exe_i.ctrl.rd;
            wb_q.wdata  <= (exe_i.ctrl.wb_sel == WB_LINK) ? link_i : alu_result_i;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_q.valid && wb_q.rf_wen && wb_q.rd != '0 && int'(wb_q.rd) < NUM_REGS) begin
            regs[wb_q.rd[IDX_W-1:0]] <= wb_q.wdata;
        end
    end

    assign retire_o = wb_q;

endmodule

`default_nettype wire

// File: verilog/rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(
    parameter int NUM_REGS = 32
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  core_pkg::fetch_t    fetch_i,
    output core_pkg::redirect_t redirect_o,
    output core_pkg::retire_t   retire_o
);
    import core_pkg::*;

    fetch_t    dec_q;
    exe_t      exe_q;
    redirect_t redirect_q;

    ctrl_t dec_ctrl;
    word_t dec_imm;
    word_t dec_op1;
    word_t dec_op2;
    word_t dec_rs2_val;

    word_t alu_result;
    logic  br_taken;
    word_t br_target;
    word_t br_link;
    logic  flush;
    fwd_t  exe_fwd;

    // taken branch or jump in execute kills everything younger
    assign flush = exe_q.valid & br_taken;

    always_comb begin
        exe_fwd.valid = exe_q.valid & exe_q.ctrl.rf_wen;
        exe_fwd.rd    = exe_q.ctrl.rd;
        exe_fwd.data  = (exe_q.ctrl.wb_sel == WB_LINK) ? br_link : alu_result;
    end

    ////////////////////
    // pipeline registers

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dec_q.valid <= 1'b0;
        end else begin
            // fetch during the redirect cycle is still on the old path
            dec_q.valid <= fetch_i.valid & ~flush & ~redirect_q.valid;
            dec_q.pc    <= fetch_i.pc;
            dec_q.inst  <= fetch_i.inst;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            exe_q.valid <= 1'b0;
        end else begin
            exe_q.valid   <= dec_q.valid & ~flush;
            exe_q.pc      <= dec_q.pc;
            exe_q.ctrl    <= dec_ctrl;
            exe_q.op1     <= dec_op1;
            exe_q.op2     <= dec_op2;
            exe_q.rs2_val <= dec_rs2_val;
            exe_q.imm     <= dec_imm;
        end
    end

    // registered so fetch never sees the execute compare directly
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            redirect_q.valid <= 1'b0;
        end else begin
            redirect_q.valid <= flush;
            redirect_q.pc    <= br_target;
        end
    end

    assign redirect_o = redirect_q;

    ////////////////////
    // datapath

    inst_decode u_decode (
        .inst_i (dec_q.inst),
        .ctrl_o (dec_ctrl),
        .imm_o  (dec_imm)
    );

    int_alu u_alu (
        .op_i     (exe_q.ctrl.alu_op),
        .a_i      (exe_q.op1),
        .b_i      (exe_q.op2),
        .result_o (alu_result)
    );

    branch_unit u_branch (
        .br_i     (exe_q.ctrl.br_op),
        .pc_i     (exe_q.pc),
        .rs1_i    (exe_q.op1),
        .rs2_i    (exe_q.rs2_val),
        .imm_i    (exe_q.imm),
        .taken_o  (br_taken),
        .target_o (br_target),
        .link_o   (br_link)
    );

    reg_file_wb #(
        .NUM_REGS (NUM_REGS)
    ) u_rf_wb (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .dec_valid_i  (dec_q.valid),
        .ctrl_i       (dec_ctrl),
        .pc_i         (dec_q.pc),
        .imm_i        (dec_imm),
        .exe_fwd_i    (exe_fwd),
        .exe_i        (exe_q),
        .alu_result_i (alu_result),
        .link_i       (br_link),
        .flush_i      (flush),
        .op1_o        (dec_op1),
        .op2_o        (dec_op2),
        .rs2_val_o    (dec_rs2_val),
        .retire_o     (retire_o)
    );

endmodule

`default_nettype wire

// File: test/tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core;
    import core_pkg::*;

    localparam int NUM_REGS = 32;

    logic      clk;
    logic      rst_n_i;
    fetch_t    fetch_i;
    redirect_t redirect_o;
    retire_t   retire_o;

    word_t   prog [128];
    int      plen;
    word_t   mregs [NUM_REGS];
    retire_t exp_q [$];
    word_t   exp_redir_q [$];
    integer  seed;
    int      err_count;
    int      check_count;
    int      tests_run;
    int      tests_failed;
    int      cycles;
    int      cycle_limit = 50;

    rv_core_top #(
        .NUM_REGS (NUM_REGS)
    ) dut_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .fetch_i    (fetch_i),
        .redirect_o (redirect_o),
        .retire_o   (retire_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // run limit grows with every program loaded
    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the core stopped retiring", cycles);
        $display("Checks failed");
        $finish;
    end

    ////////////////////
    // encoders and program memory

    function automatic word_t rr_inst(input logic [2:0] f3, input logic [6:0] f7,
                                      input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t imm_inst(input logic [6:0] opc, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t br_inst(input logic [2:0] f3, input logic [4:0] rs1,
                                      input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic word_t upper_inst(input logic [6:0] opc, input logic [4:0] rd,
                                         input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic word_t jal_inst(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    task automatic emit(input word_t w);
        prog[plen] = w;
        plen++;
    endtask

    ////////////////////
    // reference ISA model

    function automatic word_t read_reg(input logic [4:0] idx);
        if (idx == 5'd0 || int'(idx) >= NUM_REGS) begin
            return '0;
        end
        return mregs[idx];
    endfunction

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t x, input word_t y);
        logic signed [31:0] sx;
        sx = x;
        case (f3)
            3'd0: return alt ? x - y : x + y;
            3'd1: return x << y[4:0];
            3'd2: return {31'b0, $signed(x) < $signed(y)};
            3'd3: return {31'b0, x < y};
            3'd4: return x ^ y;
            3'd5: begin
                if (alt) begin
                    return sx >>> y[4:0];
                end
                return x >> y[4:0];
            end
            3'd6: return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input word_t x, input word_t y);
        case (f3)
            3'd0: return x == y;
            3'd1: return x != y;
            3'd4: return $signed(x) < $signed(y);
            3'd5: return $signed(x) >= $signed(y);
            3'd6: return x < y;
            3'd7: return x >= y;
            default: return 1'b0;
        endcase
    endfunction

    // executes prog in order, queueing retires and redirect targets
    task automatic model_run();
        word_t   pc;
        word_t   ins;
        word_t   a;
        word_t   b;
        word_t   i_imm;
        word_t   res;
        word_t   npc;
        logic    taken;
        retire_t r;
        int      steps;
        pc = '0;
        steps = 0;
        while (pc < word_t'(4 * plen) && steps < 4 * plen) begin
            ins   = prog[pc >> 2];
            a     = read_reg(ins[19:15]);
            b     = read_reg(ins[24:20]);
            i_imm = {{20{ins[31]}}, ins[31:20]};
            taken = 1'b0;
            npc   = pc + 4;
            r     = '0;
            case (ins[6:0])
                OPC_OP: begin
                    r.rf_wen = 1'b1;
                    res = alu_ref(ins[14:12], ins[30], a, b);
                end
                OPC_OPIMM: begin
                    r.rf_wen = 1'b1;
                    res = alu_ref(ins[14:12], ins[30] & (ins[14:12] == 3'd5), a, i_imm);
                end
                OPC_LUI: begin
                    r.rf_wen = 1'b1;
                    res = {ins[31:12], 12'h000};
                end
                OPC_AUIPC: begin
                    r.rf_wen = 1'b1;
                    res = pc + {ins[31:12], 12'h000};
                end
                OPC_JAL: begin
                    r.rf_wen = 1'b1;
                    res = pc + 4;
                    taken = 1'b1;
                    npc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                OPC_JALR: begin
                    r.rf_wen = 1'b1;
                    res = pc + 4;
                    taken = 1'b1;
                    npc = (a + i_imm) & ~32'h1;
                end
                OPC_BRANCH: begin
                    res = '0;
                    taken = branch_ref(ins[14:12], a, b);
                    if (taken) begin
                        npc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                    end
                end
                default: res = '0;
            endcase
            r.valid = 1'b1;
            r.pc    = pc;
            r.rd    = ins[11:7];
            r.wdata = res;
            exp_q.push_back(r);
            if (r.rf_wen && r.rd != 5'd0 && int'(r.rd) < NUM_REGS) begin
                mregs[r.rd] = res;
            end
            if (taken) begin
                exp_redir_q.push_back(npc);
            end
            pc = npc;
            steps++;
        end
    endtask

    ////////////////////
    // driver and checks

    task automatic check_val(input string what, input word_t got, input word_t exp);
        check_count++;
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    // feeds prog from pc 0, follows redirects, checks every retire
    task automatic run_program(input string name);
        word_t   pc;
        word_t   prog_end;
        retire_t exp_r;
        int      idle;
        int      errs_before;
        errs_before = err_count;
        cycle_limit += 4 * plen;
        prog_end = 4 * plen;
        model_run();
        pc = '0;
        idle = 0;
        while (idle < 4) begin
            @(posedge clk);
            if (retire_o.valid) begin
                if (exp_q.size() == 0) begin
                    $display("unexpected retire of pc %h at %0t", retire_o.pc, $time);
                    err_count++;
                end else begin
                    exp_r = exp_q.pop_front();
                    check_val("retire_o.pc", retire_o.pc, exp_r.pc);
                    check_val("retire_o.rf_wen", retire_o.rf_wen, exp_r.rf_wen);
                    if (exp_r.rf_wen) begin
                        check_val("retire_o.rd", retire_o.rd, exp_r.rd);
                        check_val("retire_o.wdata", retire_o.wdata, exp_r.wdata);
                    end
                end
            end
            if (redirect_o.valid) begin
                if (exp_redir_q.size() == 0) begin
                    $display("unexpected redirect to %h at %0t", redirect_o.pc, $time);
                    err_count++;
                end else begin
                    check_val("redirect_o.pc", redirect_o.pc, exp_redir_q.pop_front());
                end
                pc = redirect_o.pc;
            end
            if (pc < prog_end) begin
                fetch_i.valid <= 1'b1;
                fetch_i.pc    <= pc;
                fetch_i.inst  <= prog[pc >> 2];
                pc = pc + 4;
            end else begin
                fetch_i.valid <= 1'b0;
            end
            if (pc >= prog_end && exp_q.size() == 0 && exp_redir_q.size() == 0) begin
                idle++;
            end else begin
                idle = 0;
            end
        end
        tests_run++;
        if (err_count != errs_before) begin
            tests_failed++;
        end
        $display("test %-12s %s (%0d errors)", name,
                 (err_count == errs_before) ? "ok" : "FAIL", err_count - errs_before);
    endtask

    ////////////////////
    // directed tests

    task automatic alu_ops_test();
        word_t      rnd;
        logic [4:0] rd;
        logic [2:0] f3;
        logic [11:0] imm;
        logic       alt;
        plen = 0;
        for (int r = 1; r < 16; r++) begin
            rnd = $random(seed);
            emit(upper_inst(OPC_LUI, 5'(r), rnd[31:12]));
            emit(imm_inst(OPC_OPIMM, 3'd0, 5'(r), 5'(r), rnd[11:0]));
        end
        for (int n = 0; n < 32; n++) begin
            rnd = $random(seed);
            rd  = (rnd[3:0] == 4'd0) ? 5'd1 : {1'b0, rnd[3:0]};
            f3  = 3'(n);
            // second half uses sub, sra and srai
            alt = n[4] & (f3 == 3'd0 || f3 == 3'd5);
            imm = rnd[28:17];
            if (n[3]) begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    imm = {1'b0, alt, 5'd0, imm[4:0]};
                end
                emit(imm_inst(OPC_OPIMM, f3, rd, {1'b0, rnd[7:4]}, imm));
            end else begin
                emit(rr_inst(f3, {1'b0, alt, 5'd0}, rd, {1'b0, rnd[7:4]}, {1'b0, rnd[11:8]}));
            end
        end
        run_program("alu_ops");
    endtask

    task automatic forwarding_test();
        plen = 0;
        emit(imm_inst(OPC_OPIMM, 3'd0, 5'd1, 5'd0, 12'd5));
        emit(imm_inst(OPC_OPIMM, 3'd0, 5'd2, 5'd1, 12'd3));
        emit(rr_inst(3'd0, 7'h00, 5'd3, 5'd2, 5'd1));
        emit(rr_inst(3'd0, 7'h20, 5'd4, 5'd3, 5'd2));
        // newest of two back-to-back writes must win
        emit(imm_inst(OPC_OPIMM, 3'd0, 5'd4, 5'd4, 12'hfff));
        emit(imm_inst(OPC_OPIMM, 3'd0, 5'd4, 5'd4, 12'hfff));
        emit(rr_inst(3'd7, 7'h00, 5'd5, 5'd4, 5'd4));
        emit(imm_inst(OPC_OPIMM, 3'd0, 5'd6, 5'd0, 12'd1));
        emit(imm_inst(OPC_OPIMM, 3'd0, 5'd7, 5'd0, 12'd9));
        emit(rr_inst(3'd1, 7'h00, 5'd8, 5'd5, 5'd6));
        emit(rr_inst(3'd4, 7'h00, 5'd9, 5'd7, 5'd8));
        run_program("forwarding");
    endtask

    task automatic branch_test();
        plen = 0;
        emit(imm_inst(OPC_OPIMM, 3'd0, 5'd1, 5'd0, 12'd5));
        emit(imm_inst(OPC_OPIMM, 3'd0, 5'd2, 5'd0, 12'hffd));
        emit(imm_inst(OPC_OPIMM, 3'd0, 5'd3, 5'd0, 12'd5));
        emit(imm_inst(OPC_OPIMM, 3'd0, 5'd20, 5'd0, 12'd0));
        emit(br_inst(3'd0, 5'd1, 5'd3, 13'd12));
        emit(imm_inst(OPC_OPIMM, 3'd0, 5'd20, 5'd0, 12'd1));
        emit(imm_inst(OPC_OPIMM, 3'd0, 5'd20, 5'd0, 12'd2));
        emit(br_inst(3'd1, 5'd1, 5'd3, 13'd8));
        emit(br_inst(3'd4, 5'd2, 5'd1, 13'd12));
        emit(imm_inst(OPC_OPIMM, 3'd0, 5'd20, 5'd0, 12'd3));
        emit(imm_inst(OPC_OPIMM, 3'd0, 5'd20, 5'd0, 12'd4));
        emit(br_inst(3'd6, 5'd2, 5'd1, 13'd8));
        emit(br_inst(3'd5, 5'd1, 5'd2, 13'd8));
        emit(imm_inst(OPC_OPIMM, 3'd0, 5'd20, 5'd0, 12'd5));
        emit(br_inst(3'd7, 5'd2, 5'd1, 13'd8));
        emit(imm_inst(OPC_OPIMM, 3'd0, 5'd20, 5'd0, 12'd6));
        // countdown loop taken backward twice before falling through
        emit(imm_inst(OPC_OPIMM, 3'd0, 5'd4, 5'd0, 12'd3));
        emit(imm_inst(OPC_OPIMM, 3'd0, 5'd4, 5'd4, 12'hfff));
        emit(br_inst(3'd1, 5'd4, 5'd0, -13'sd4));
        emit(rr_inst(3'd0, 7'h00, 5'd21, 5'd20, 5'd4));
        run_program("branches");
    endtask

    task automatic jump_test();
        plen = 0;
        emit(imm_inst(OPC_OPIMM, 3'd0, 5'd2, 5'd0, 12'd0));
        emit(jal_inst(5'd1, 21'd12));
        emit(imm_inst(OPC_OPIMM, 3'd0, 5'd2, 5'd0, 12'd1));
        emit(imm_inst(OPC_OPIMM, 3'd0, 5'd2, 5'd0, 12'd2));
        emit(upper_inst(OPC_AUIPC, 5'd5, 20'd0));
        // odd base so the jalr target drops to the word below
        emit(imm_inst(OPC_OPIMM, 3'd0, 5'd5, 5'd5, 12'd17));
        emit(imm_inst(OPC_JALR, 3'd0, 5'd6, 5'd5, 12'd0));
        emit(imm_inst(OPC_OPIMM, 3'd0, 5'd2, 5'd0, 12'd3));
        emit(rr_inst(3'd0, 7'h00, 5'd7, 5'd1, 5'd6));
        emit(imm_inst(OPC_JALR, 3'd0, 5'd0, 5'd5, 12'd11));
        emit(imm_inst(OPC_OPIMM, 3'd0, 5'd2, 5'd0, 12'd4));
        emit(jal_inst(5'd0, 21'd8));
        emit(imm_inst(OPC_OPIMM, 3'd0, 5'd2, 5'd0, 12'd5));
        emit(rr_inst(3'd0, 7'h00, 5'd9, 5'd7, 5'd2));
        run_program("jumps");
    endtask

    task automatic special_test();
        plen = 0;
        emit(upper_inst(OPC_LUI, 5'd10, 20'habcde));
        emit(upper_inst(OPC_AUIPC, 5'd11, 20'h12345));
        emit(imm_inst(OPC_OPIMM, 3'd0, 5'd0, 5'd0, 12'd55));
        emit(upper_inst(OPC_LUI, 5'd0, 20'h00001));
        emit(rr_inst(3'd0, 7'h00, 5'd12, 5'd0, 5'd10));
        // unknown opcodes where the first has rd set
        emit(32'h0000_0f80);
        emit(32'hffff_ffff);
        emit(imm_inst(OPC_OPIMM, 3'd0, 5'd13, 5'd12, 12'd1));
        emit(rr_inst(3'd6, 7'h00, 5'd15, 5'd11, 5'd0));
        run_program("special");
    endtask

    initial begin
        seed         = 32'h8440e388;
        rst_n_i      = 1'b0;
        fetch_i      = '0;
        err_count    = 0;
        check_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        plen         = 0;
        for (int r = 0; r < NUM_REGS; r++) begin
            mregs[r] = '0;
        end
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;
        alu_ops_test();
        forwarding_test();
        branch_test();
        jump_test();
        special_test();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, err_count);
        if (err_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
verilog/core_pkg.sv
verilog/inst_decode.sv
verilog/int_alu.sv
verilog/branch_unit.sv
verilog/reg_file_wb.sv
verilog/rv_core_top.sv
test/tb_core.sv
